/* include/addr_map.svh */
`ifndef ADDR_MAP_SVH
`define ADDR_MAP_SVH

// soc side sram
// window length is four bytes per word of SRAM_WORDS
`define SRAM_BASE 32'h8000_0000

// rtc cycle counter
// low half at +0, high half at +4
`define RTC_BASE 32'ha000_0048
`define RTC_SIZE 32'd8

`endif

/* hdl/soc_pkg.sv */
package soc_pkg;

	// axi response codes
	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		EXOKAY = 2'b01,
		SLVERR = 2'b10,
		DECERR = 2'b11
	} axi_resp_e;

	// byte offsets of the rtc counter halves inside its window
	localparam logic [2:0] RTC_LO_OFS = 3'd0;
	localparam logic [2:0] RTC_HI_OFS = 3'd4;

	// master to slave on all five channels
	typedef struct packed {
		// write address
		logic [31:0] awaddr;
		logic        awvalid;
		// write data
		logic [31:0] wdata;
		logic [3:0]  wstrb;
		logic        wvalid;
		// write response
		logic        bready;
		// read address
		logic [31:0] araddr;
		logic        arvalid;
		// read data
		logic        rready;
	} axi_req_t;

	// slave to master
	typedef struct packed {
		// write address and data
		logic        awready;
		logic        wready;
		// write response
		axi_resp_e   bresp;
		logic        bvalid;
		// read address
		logic        arready;
		// read data
		logic [31:0] rdata;
		axi_resp_e   rresp;
		logic        rvalid;
	} axi_rsp_t;

endpackage

/* hdl/axi_xbar.sv */
`timescale 1ns/1ps
`include "addr_map.svh"

module axi_xbar #(
	parameter int SRAM_WORDS = 256
) (
	input  logic              clk,
	input  logic              rst,
	input  soc_pkg::axi_req_t m_req,
	output soc_pkg::axi_rsp_t m_rsp,
	output soc_pkg::axi_req_t sram_req,
	input  soc_pkg::axi_rsp_t sram_rsp,
	output soc_pkg::axi_req_t rtc_req,
	input  soc_pkg::axi_rsp_t rtc_rsp
);
	import soc_pkg::*;

	typedef enum logic [2:0] {
		IDLE,
		RD_SRAM,
		RD_RTC,
		RD_ERR,
		WR_SRAM,
		WR_ERR
	} state_e;

	// first byte past the sram window
	localparam logic [31:0] SRAM_LIMIT = `SRAM_BASE + 32'(SRAM_WORDS * 4);

	state_e    state;
	axi_resp_e err_code;
	// low while the error responder accepts, high while it answers
	logic      err_phase;

	function automatic logic in_sram(input logic [31:0] addr);
		return (addr >= `SRAM_BASE) && (addr < SRAM_LIMIT);
	endfunction

	function automatic logic in_rtc(input logic [31:0] addr);
		return (addr >= `RTC_BASE) && (addr < `RTC_BASE + `RTC_SIZE);
	endfunction

	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= IDLE;
			err_code  <= OKAY;
			err_phase <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					err_phase <= 1'b0;
					// reads win over writes
					if (m_req.arvalid) begin
						if (in_sram(m_req.araddr)) begin
							state <= RD_SRAM;
						end else if (in_rtc(m_req.araddr)) begin
							state <= RD_RTC;
						end else begin
							state    <= RD_ERR;
							err_code <= DECERR;
						end
					end else if (m_req.awvalid && m_req.wvalid) begin
						if (in_sram(m_req.awaddr)) begin
							state <= WR_SRAM;
						end else if (in_rtc(m_req.awaddr)) begin
							// rtc is read only
							state    <= WR_ERR;
							err_code <= SLVERR;
						end else begin
							state    <= WR_ERR;
							err_code <= DECERR;
						end
					end
				end
				RD_SRAM: begin
					if (m_req.rready && sram_rsp.rvalid)
						state <= IDLE;
				end
				RD_RTC: begin
					if (m_req.rready && rtc_rsp.rvalid)
						state <= IDLE;
				end
				WR_SRAM: begin
					if (m_req.bready && sram_rsp.bvalid)
						state <= IDLE;
				end
				RD_ERR: begin
					if (!err_phase)
						err_phase <= 1'b1;
					else if (m_req.rready)
						state <= IDLE;
				end
				WR_ERR: begin
					if (!err_phase)
						err_phase <= 1'b1;
					else if (m_req.bready)
						state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// unrouted channels stay at zero
	always_comb begin
		m_rsp    = '0;
		sram_req = '0;
		rtc_req  = '0;
		case (state)
			RD_SRAM: begin
				sram_req.araddr  = m_req.araddr;
				sram_req.arvalid = m_req.arvalid;
				sram_req.rready  = m_req.rready;
				m_rsp.arready    = sram_rsp.arready;
				m_rsp.rdata      = sram_rsp.rdata;
				m_rsp.rresp      = sram_rsp.rresp;
				m_rsp.rvalid     = sram_rsp.rvalid;
			end
			RD_RTC: begin
				rtc_req.araddr  = m_req.araddr;
				rtc_req.arvalid = m_req.arvalid;
				rtc_req.rready  = m_req.rready;
				m_rsp.arready   = rtc_rsp.arready;
				m_rsp.rdata     = rtc_rsp.rdata;
				m_rsp.rresp     = rtc_rsp.rresp;
				m_rsp.rvalid    = rtc_rsp.rvalid;
			end
			WR_SRAM: begin
				sram_req.awaddr  = m_req.awaddr;
				sram_req.awvalid = m_req.awvalid;
				sram_req.wdata   = m_req.wdata;
				sram_req.wstrb   = m_req.wstrb;
				sram_req.wvalid  = m_req.wvalid;
				sram_req.bready  = m_req.bready;
				m_rsp.awready    = sram_rsp.awready;
				m_rsp.wready     = sram_rsp.wready;
				m_rsp.bresp      = sram_rsp.bresp;
				m_rsp.bvalid     = sram_rsp.bvalid;
			end
			RD_ERR: begin
				// rdata stays zero
				m_rsp.arready = !err_phase;
				m_rsp.rvalid  = err_phase;
				m_rsp.rresp   = err_phase ? err_code : OKAY;
			end
			WR_ERR: begin
				m_rsp.awready = !err_phase;
				m_rsp.wready  = !err_phase;
				m_rsp.bvalid  = err_phase;
				m_rsp.bresp   = err_phase ? err_code : OKAY;
			end
			default: begin
				m_rsp = '0;
			end
		endcase
	end

endmodule

/* hdl/sram_slave.sv */
`timescale 1ns/1ps

module sram_slave #(
	parameter int SRAM_WORDS = 256
) (
	input  logic              clk,
	input  logic              rst,
	input  soc_pkg::axi_req_t req,
	output soc_pkg::axi_rsp_t rsp
);
	import soc_pkg::*;

	localparam int IDX_W = $clog2(SRAM_WORDS);

	logic [31:0]      mem [SRAM_WORDS];
	logic [IDX_W-1:0] rd_idx;
	logic [IDX_W-1:0] wr_idx;

	logic        arready_q;
	logic        rvalid_q;
	logic [31:0] rdata_q;
	logic        wready_q;
	logic        bvalid_q;
	logic        rd_fire;
	logic        wr_fire;

	// word index without the byte offset bits
	assign rd_idx = req.araddr[IDX_W+1:2];
	assign wr_idx = req.awaddr[IDX_W+1:2];

	assign rd_fire = req.arvalid && arready_q;
	assign wr_fire = req.awvalid && req.wvalid && wready_q;

	// read side
	always_ff @(posedge clk) begin
		if (rst) begin
			arready_q <= 1'b0;
			rvalid_q  <= 1'b0;
		end else begin
			// one cycle pulse while no response is pending
			arready_q <= req.arvalid && !arready_q && !rvalid_q;
			if (rd_fire)
				rvalid_q <= 1'b1;
			else if (rvalid_q && req.rready)
				rvalid_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_fire)
			rdata_q <= mem[rd_idx];
	end

	// write address and data accepted together
	always_ff @(posedge clk) begin
		if (rst) begin
			wready_q <= 1'b0;
			bvalid_q <= 1'b0;
		end else begin
			wready_q <= req.awvalid && req.wvalid && !wready_q && !bvalid_q;
			if (wr_fire)
				bvalid_q <= 1'b1;
			else if (bvalid_q && req.bready)
				bvalid_q <= 1'b0;
		end
	end

	// byte lanes under wstrb
	always_ff @(posedge clk) begin
		if (wr_fire) begin
			for (int b = 0; b < 4; b++) begin
				if (req.wstrb[b])
					mem[wr_idx][b*8 +: 8] <= req.wdata[b*8 +: 8];
			end
		end
	end

	assign rsp.awready = wready_q;
	assign rsp.wready  = wready_q;
	assign rsp.bresp   = OKAY;
	assign rsp.bvalid  = bvalid_q;
	assign rsp.arready = arready_q;
	assign rsp.rdata   = rdata_q;
	assign rsp.rresp   = OKAY;
	assign rsp.rvalid  = rvalid_q;

endmodule

/* hdl/rtc_timer.sv */
`timescale 1ns/1ps

module rtc_timer (
	input  logic              clk,
	input  logic              rst,
	input  soc_pkg::axi_req_t req,
	output soc_pkg::axi_rsp_t rsp
);
	import soc_pkg::*;

	logic [63:0] count;
	logic [31:0] hi_latch;
	logic        arready_q;
	logic        rvalid_q;
	logic [31:0] rdata_q;
	logic        rd_fire;

	assign rd_fire = req.arvalid && arready_q;

	// free running cycle count
	always_ff @(posedge clk) begin
		if (rst)
			count <= '0;
		else
			count <= count + 64'd1;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			arready_q <= 1'b0;
			rvalid_q  <= 1'b0;
			hi_latch  <= '0;
		end else begin
			arready_q <= req.arvalid && !arready_q && !rvalid_q;
			if (rd_fire) begin
				rvalid_q <= 1'b1;
				// snapshot high half with the low read so both halves match
				if (req.araddr[2:0] == RTC_LO_OFS)
					hi_latch <= count[63:32];
			end else if (rvalid_q && req.rready) begin
				rvalid_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rd_fire) begin
			case (req.araddr[2:0])
				RTC_LO_OFS: rdata_q <= count[31:0];
				RTC_HI_OFS: rdata_q <= hi_latch;
				// rest of the window mirrors the high half
				default: rdata_q <= hi_latch;
			endcase
		end
	end

	// write channels never answered
	assign rsp.awready = 1'b0;
	assign rsp.wready  = 1'b0;
	assign rsp.bresp   = OKAY;
	assign rsp.bvalid  = 1'b0;
	assign rsp.arready = arready_q;
	assign rsp.rdata   = rdata_q;
	assign rsp.rresp   = OKAY;
	assign rsp.rvalid  = rvalid_q;

endmodule

/* hdl/soc_top.sv */
`timescale 1ns/1ps

module soc_top #(
	parameter int SRAM_WORDS = 256
) (
	input  logic              clk,
	input  logic              rst,
	input  soc_pkg::axi_req_t m_req,
	output soc_pkg::axi_rsp_t m_rsp
);
	import soc_pkg::*;

	// crossbar to sram
	axi_req_t sram_req;
	axi_rsp_t sram_rsp;

	// crossbar to rtc where only the read fields carry traffic
	axi_req_t rtc_req;
	axi_rsp_t rtc_rsp;

	axi_xbar #(
		.SRAM_WORDS(SRAM_WORDS)
	) u_xbar (
		.clk      (clk),
		.rst      (rst),
		.m_req    (m_req),
		.m_rsp    (m_rsp),
		.sram_req (sram_req),
		.sram_rsp (sram_rsp),
		.rtc_req  (rtc_req),
		.rtc_rsp  (rtc_rsp)
	);

	sram_slave #(
		.SRAM_WORDS(SRAM_WORDS)
	) u_sram (
		.clk (clk),
		.rst (rst),
		.req (sram_req),
		.rsp (sram_rsp)
	);

	rtc_timer u_rtc (
		.clk (clk),
		.rst (rst),
		.req (rtc_req),
		.rsp (rtc_rsp)
	);

endmodule

/* verification/clk_gen.sv */
`timescale 1ns/1ps

module clk_gen (
	output logic clk,
	output logic rst
);

	// 4 ns period
	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// reset held for the first four rising edges
	initial begin
		rst = 1'b1;
		repeat (4) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

/* verification/tb_soc.sv */
`timescale 1ns/1ps
`include "addr_map.svh"

module tb_soc;
	import soc_pkg::*;

	localparam int SRAM_WORDS = 256;
	localparam logic [31:0] SEED = 32'h38ca;
	localparam int CYCLES_PER_LINE = 40;

	typedef struct packed {
		logic [7:0]  op;
		logic [31:0] addr;
		logic [31:0] data;
		logic [3:0]  strb;
		logic [31:0] exp_data;
		logic [1:0]  exp_resp;
	} stim_t;

	logic     clk;
	logic     rst;
	axi_req_t m_req;
	axi_rsp_t m_rsp;

	stim_t stim_q[$];
	int    error_count = 0;
	int    check_count = 0;
	int    cycle_count = 0;
	int    cycle_limit = 0;

	clk_gen u_clk (
		.clk (clk),
		.rst (rst)
	);

	soc_top #(
		.SRAM_WORDS(SRAM_WORDS)
	) uut (
		.clk   (clk),
		.rst   (rst),
		.m_req (m_req),
		.m_rsp (m_rsp)
	);

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic finish_run();
		$display("checks %0d, errors %0d", check_count, error_count);
		if (error_count == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	endtask

	// response the address map gives for a transaction
	function automatic logic [1:0] map_resp(input logic [7:0] op, input logic [31:0] addr);
		logic in_sram;
		logic in_rtc;
		in_sram = (addr >= `SRAM_BASE) && (addr < `SRAM_BASE + 32'(SRAM_WORDS * 4));
		in_rtc  = (addr >= `RTC_BASE) && (addr < `RTC_BASE + `RTC_SIZE);
		if (in_sram)
			return OKAY;
		else if (in_rtc)
			return (op == "W") ? SLVERR : OKAY;
		else
			return DECERR;
	endfunction

	task automatic load_stim();
		int          fd;
		int          n;
		int          line_no;
		string       line;
		logic [7:0]  op;
		logic [31:0] addr;
		logic [31:0] data;
		logic [3:0]  strb;
		logic [31:0] exp_data;
		logic [1:0]  exp_resp;
		line_no = 0;
		fd = $fopen("verification/xbar_stim.txt", "r");
		if (fd == 0) begin
			error_count++;
			$display("cannot open stimulus file verification/xbar_stim.txt");
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			op = " ";
			void'($fgets(line, fd));
			line_no++;
			n = $sscanf(line, "%c %h %h %h %h %h", op, addr, data, strb, exp_data, exp_resp);
			// comments and blank lines
			if (n <= 0 || op == "#" || op == " " || op == "\n")
				continue;
			if (n != 6) begin
				error_count++;
				$display("stimulus line %0d is malformed", line_no);
				continue;
			end
			if (map_resp(op, addr) != exp_resp) begin
				error_count++;
				$display("stimulus line %0d expects a response the address map does not give",
					line_no);
			end
			stim_q.push_back({op, addr, data, strb, exp_data, exp_resp});
		end
		$fclose(fd);
	endtask

	// response must hold still through a random wait before ready
	task automatic accept_write_resp(output logic [1:0] resp);
		int delay;
		do @(negedge clk); while (!m_rsp.bvalid);
		resp = m_rsp.bresp;
		delay = $urandom % 4;
		repeat (delay) begin
			@(negedge clk);
			check_val("m_rsp.bvalid", m_rsp.bvalid, 1);
			check_val("m_rsp.bresp", m_rsp.bresp, resp);
		end
		@(posedge clk);
		m_req.bready <= 1'b1;
		@(negedge clk);
		check_val("m_rsp.bvalid", m_rsp.bvalid, 1);
		check_val("m_rsp.bresp", m_rsp.bresp, resp);
		@(posedge clk);
		m_req.bready <= 1'b0;
	endtask

	task automatic accept_read_resp(output logic [31:0] data, output logic [1:0] resp);
		int delay;
		do @(negedge clk); while (!m_rsp.rvalid);
		data = m_rsp.rdata;
		resp = m_rsp.rresp;
		delay = $urandom % 4;
		repeat (delay) begin
			@(negedge clk);
			check_val("m_rsp.rvalid", m_rsp.rvalid, 1);
			check_val("m_rsp.rdata", m_rsp.rdata, data);
			check_val("m_rsp.rresp", m_rsp.rresp, resp);
		end
		@(posedge clk);
		m_req.rready <= 1'b1;
		@(negedge clk);
		check_val("m_rsp.rvalid", m_rsp.rvalid, 1);
		check_val("m_rsp.rdata", m_rsp.rdata, data);
		check_val("m_rsp.rresp", m_rsp.rresp, resp);
		@(posedge clk);
		m_req.rready <= 1'b0;
	endtask

	task automatic write_word(input logic [31:0] addr, input logic [31:0] data,
		input logic [3:0] strb, output logic [1:0] resp);
		@(posedge clk);
		m_req.awaddr  <= addr;
		m_req.awvalid <= 1'b1;
		m_req.wdata   <= data;
		m_req.wstrb   <= strb;
		m_req.wvalid  <= 1'b1;
		do @(negedge clk); while (!(m_rsp.awready && m_rsp.wready));
		@(posedge clk);
		m_req.awvalid <= 1'b0;
		m_req.wvalid  <= 1'b0;
		accept_write_resp(resp);
	endtask

	task automatic read_word(input logic [31:0] addr, output logic [31:0] data,
		output logic [1:0] resp);
		@(posedge clk);
		m_req.araddr  <= addr;
		m_req.arvalid <= 1'b1;
		do @(negedge clk); while (!m_rsp.arready);
		@(posedge clk);
		m_req.arvalid <= 1'b0;
		accept_read_resp(data, resp);
	endtask

	initial begin
		stim_t       s;
		logic [31:0] data;
		logic [31:0] data2;
		logic [1:0]  resp;
		logic [1:0]  resp2;
		void'($urandom(SEED));
		m_req = '0;
		load_stim();
		if (stim_q.size() == 0) begin
			error_count++;
			$display("no stimulus lines were loaded");
		end else begin
			cycle_limit = stim_q.size() * CYCLES_PER_LINE;
			@(negedge rst);
			foreach (stim_q[i]) begin
				s = stim_q[i];
				case (s.op)
					"W": begin
						write_word(s.addr, s.data, s.strb, resp);
						check_val("m_rsp.bresp", resp, s.exp_resp);
					end
					"R": begin
						read_word(s.addr, data, resp);
						check_val("m_rsp.rresp", resp, s.exp_resp);
						check_val("m_rsp.rdata", data, s.exp_data);
					end
					"T": begin
						// second low read must be larger as the counter keeps running
						read_word(s.addr, data, resp);
						read_word(s.addr, data2, resp2);
						check_val("m_rsp.rresp", resp, s.exp_resp);
						check_val("m_rsp.rresp", resp2, s.exp_resp);
						check_val("rtc low increasing", data2 > data, 1);
					end
					default: begin
						error_count++;
						$display("unknown operation letter in stimulus entry %0d", i);
					end
				endcase
			end
		end
		finish_run();
	end

	// watchdog
	initial begin
		wait (cycle_limit > 0);
		while (cycle_count < cycle_limit) begin
			@(posedge clk);
			cycle_count++;
		end
		error_count++;
		$display("timeout waiting for a response");
		finish_run();
	end

endmodule

/* verification/xbar_stim.txt */
# op addr data strb exp_data exp_resp, all hex except op
# op W write, R read, T two rtc low reads; resp 0 OKAY, 2 SLVERR, 3 DECERR
W 80000000 12345678 f 00000000 0
W 80000004 deadbeef f 00000000 0
W 800003fc a5a55a5a f 00000000 0
R 80000000 00000000 0 12345678 0
R 80000004 00000000 0 deadbeef 0
R 800003fc 00000000 0 a5a55a5a 0
W 80000010 11223344 f 00000000 0
W 80000010 aabbccdd 5 00000000 0
R 80000010 00000000 0 11bb33dd 0
W 80000010 99000000 8 00000000 0
R 80000010 00000000 0 99bb33dd 0
T a0000048 00000000 0 00000000 0
R a000004c 00000000 0 00000000 0
W a0000048 ffffffff f 00000000 2
R a000004c 00000000 0 00000000 0
R 90000000 00000000 0 00000000 3
W 90000000 cafef00d f 00000000 3
R 80000400 00000000 0 00000000 3
W 80000400 0badf00d f 00000000 3
R a0000050 00000000 0 00000000 3
R 80000004 00000000 0 deadbeef 0

/* build.f */
+incdir+include
hdl/soc_pkg.sv
hdl/axi_xbar.sv
hdl/sram_slave.sv
hdl/rtc_timer.sv
hdl/soc_top.sv
verification/clk_gen.sv
verification/tb_soc.sv
